//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cache_top
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100000

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- cache_assertions.sv
`timescale 1ns/1ps

module cache_assertions (
    input logic                    clk,
    input logic                    proc_reset_i,
    input cache_pkg::cache_state_e state_i,
    input logic                    hit_i,
    input logic                    mem_done_i,
    input logic                    stall_i
);
    import cache_pkg::*;

    int   fail_count = 0;
    logic waiting;

    // a memory transfer is outstanding in these states
    assign waiting = (state_i == ST_WRITEBACK) || (state_i == ST_ALLOCATE);

    // the port only completes a transfer the controller is waiting on
    done_only_while_waiting: assert property (@(posedge clk) disable iff (proc_reset_i)
        mem_done_i |-> waiting)
    else begin
        $error("memory transfer completed outside a memory wait");
        fail_count++;
    end

    // held request keeps missing until its line is refilled
    no_hit_while_waiting: assert property (@(posedge clk) disable iff (proc_reset_i)
        waiting |-> !hit_i)
    else begin
        $error("held request hit while a memory transfer was pending");
        fail_count++;
    end

    // refilled line is found by the held request in the next cycle
    refill_then_hit: assert property (@(posedge clk) disable iff (proc_reset_i)
        (state_i == ST_REFILL) |=> (hit_i && !stall_i))
    else begin
        $error("request did not hit without stall after the refill");
        fail_count++;
    end

endmodule

bind cache_controller cache_assertions assert_i (
    .clk         (clk),
    .proc_reset_i(proc_reset_i),
    .state_i     (state_q),
    .hit_i       (hit_i),
    .mem_done_i  (mem_done_i),
    .stall_i     (proc_stall_o)
);

//--- cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
    input  logic                  clk,
    input  logic                  proc_reset_i,
    input  cache_pkg::proc_req_t  proc_req_i,
    input  logic                  hit_i,
    input  cache_pkg::line_meta_t victim_meta_i,
    input  logic                  mem_done_i,
    output logic                  proc_stall_o,
    output logic                  meta_we_o,
    output cache_pkg::line_meta_t meta_wdata_o,
    output logic                  data_we_o,
    output logic                  fill_sel_o,
    output logic                  mem_start_o,
    output cache_pkg::mem_req_t   mem_req_o
);
    import cache_pkg::*;

    cache_state_e          state_q;
    cache_state_e          state_d;

    logic                  access;
    logic                  miss;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    req_index;
    logic [MEM_ADDR_W-1:0] req_line_addr;
    logic [MEM_ADDR_W-1:0] victim_line_addr;

    assign access       = proc_req_i.read | proc_req_i.write;
    assign miss         = access & ~hit_i;
    // an invalid line never needs a writeback
    assign victim_dirty = victim_meta_i.valid & victim_meta_i.dirty;

    assign req_tag          = proc_req_i.addr[ADDR_W-1 -: TAG_W];
    assign req_index        = proc_req_i.addr[OFFSET_W +: INDEX_W];
    assign req_line_addr    = proc_req_i.addr[ADDR_W-1:OFFSET_W];
    assign victim_line_addr = {victim_meta_i.tag, req_index};

    // stall for the whole miss, released once the refilled line hits in idle
    assign proc_stall_o = (state_q != ST_IDLE) | miss;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = victim_dirty ? ST_WRITEBACK : ST_ALLOCATE;
                end
            end
            ST_WRITEBACK: begin
                if (mem_done_i) begin
                    state_d = ST_ALLOCATE;
                end
            end
            ST_ALLOCATE: begin
                if (mem_done_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // store writes and memory request issue
    always_comb begin
        meta_we_o          = 1'b0;
        meta_wdata_o.valid = 1'b1;
        meta_wdata_o.dirty = 1'b0;
        meta_wdata_o.tag   = req_tag;
        data_we_o          = 1'b0;
        fill_sel_o         = 1'b0;
        mem_start_o        = 1'b0;
        // line data is supplied by the memory port from the data store
        mem_req_o          = '0;
        mem_req_o.addr     = req_line_addr;

        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    mem_start_o = 1'b1;
                    if (victim_dirty) begin
                        mem_req_o.write = 1'b1;
                        mem_req_o.addr  = victim_line_addr;
                    end else begin
                        mem_req_o.read = 1'b1;
                    end
                end else if (proc_req_i.write) begin
                    // write hit, merge word and mark dirty
                    meta_we_o          = 1'b1;
                    meta_wdata_o.dirty = 1'b1;
                    data_we_o          = 1'b1;
                end
            end
            ST_WRITEBACK: begin
                // chain the refill read onto the writeback completion
                if (mem_done_i) begin
                    mem_start_o    = 1'b1;
                    mem_req_o.read = 1'b1;
                end
            end
            ST_REFILL: begin
                meta_we_o  = 1'b1;
                data_we_o  = 1'b1;
                fill_sel_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
    input  logic                         clk,
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    input  logic                         we_i,
    input  logic                         fill_sel_i,
    input  logic [cache_pkg::WORD_W-1:0] word_wdata_i,
    input  logic [cache_pkg::LINE_W-1:0] fill_line_i,
    output logic [cache_pkg::LINE_W-1:0] line_rdata_o,
    output logic [cache_pkg::WORD_W-1:0] word_rdata_o
);
    import cache_pkg::*;

    logic [LINE_W-1:0]   lines_q [NUM_LINES];
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic [LINE_W-1:0]   cur_line;
    logic [LINE_W-1:0]   merged_line;

    assign index  = addr_i[OFFSET_W +: INDEX_W];
    assign offset = addr_i[OFFSET_W-1:0];

    assign cur_line     = lines_q[index];
    // whole line also feeds the writeback path
    assign line_rdata_o = cur_line;

    // word 0 sits in the low bits of the line
    assign word_rdata_o = cur_line[offset*WORD_W +: WORD_W];

    always_comb begin
        merged_line = cur_line;
        merged_line[offset*WORD_W +: WORD_W] = word_wdata_i;
    end

    // full line on refill, single word on a write hit
    always_ff @(posedge clk) begin
        if (we_i) begin
            if (fill_sel_i) begin
                lines_q[index] <= fill_line_i;
            end else begin
                lines_q[index] <= merged_line;
            end
        end
    end

endmodule

//--- cache_mem_port.sv
`timescale 1ns/1ps

module cache_mem_port (
    input  logic                         clk,
    input  logic                         proc_reset_i,
    input  logic                         start_i,
    input  cache_pkg::mem_req_t          req_i,
    input  logic [cache_pkg::LINE_W-1:0] line_wdata_i,
    input  logic [cache_pkg::LINE_W-1:0] mem_rdata_i,
    input  logic                         mem_ready_i,
    output cache_pkg::mem_req_t          mem_req_o,
    output logic                         done_o,
    output logic [cache_pkg::LINE_W-1:0] fill_line_o
);
    import cache_pkg::*;

    logic                  rd_q;
    logic                  wr_q;
    logic [MEM_ADDR_W-1:0] addr_q;
    logic [LINE_W-1:0]     wdata_q;
    logic [LINE_W-1:0]     fill_q;

    // transfer completes on the edge where ready meets a pending request
    assign done_o = (rd_q | wr_q) & mem_ready_i;

    // a new start wins over clearing, so writeback can chain into the read
    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else if (start_i) begin
            rd_q <= req_i.read;
            wr_q <= req_i.write;
        end else if (done_o) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_q  <= req_i.addr;
            wdata_q <= line_wdata_i;
        end
        if (done_o && rd_q) begin
            fill_q <= mem_rdata_i;
        end
    end

    always_comb begin
        mem_req_o.read  = rd_q;
        mem_req_o.write = wr_q;
        mem_req_o.addr  = addr_q;
        mem_req_o.wdata = wdata_q;
    end

    assign fill_line_o = fill_q;

endmodule

//--- cache_pkg.sv
package cache_pkg;

    // address split: tag | index | offset, word addressed
    localparam int TAG_W      = 25;
    localparam int INDEX_W    = 3;
    localparam int OFFSET_W   = 2;
    localparam int ADDR_W     = 30;
    localparam int WORD_W     = 32;
    localparam int LINE_W     = 128;
    // memory is addressed by line
    localparam int MEM_ADDR_W = 28;

    localparam int NUM_LINES  = 8;

    // processor side request, held while stalled
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } proc_req_t;

    // memory side request, held until ready
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [MEM_ADDR_W-1:0] addr;
        logic [LINE_W-1:0]     wdata;
    } mem_req_t;

    // per-line state kept in the tag store
    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } line_meta_t;

    // miss handling states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_ALLOCATE,
        ST_REFILL
    } cache_state_e;

endpackage

//--- cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
    input  logic                         clk,
    input  logic                         proc_reset_i,
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    input  logic                         we_i,
    input  cache_pkg::line_meta_t        wdata_i,
    output logic                         hit_o,
    output cache_pkg::line_meta_t        victim_meta_o
);
    import cache_pkg::*;

    line_meta_t         meta_q [NUM_LINES];
    line_meta_t         entry;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;

    assign index = addr_i[OFFSET_W +: INDEX_W];
    assign tag   = addr_i[ADDR_W-1 -: TAG_W];

    // asynchronous read of the indexed entry
    assign entry         = meta_q[index];
    assign victim_meta_o = entry;

    assign hit_o = entry.valid & (entry.tag == tag);

    // valid and dirty cleared on reset, tags keep whatever they held
    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                meta_q[i].valid <= 1'b0;
                meta_q[i].dirty <= 1'b0;
            end
        end else if (we_i) begin
            meta_q[index] <= wdata_i;
        end
    end

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                         clk,
    input  logic                         proc_reset_i,
    input  cache_pkg::proc_req_t         proc_req_i,
    output logic [cache_pkg::WORD_W-1:0] proc_rdata_o,
    output logic                         proc_stall_o,
    output cache_pkg::mem_req_t          mem_req_o,
    input  logic [cache_pkg::LINE_W-1:0] mem_rdata_i,
    input  logic                         mem_ready_i
);
    import cache_pkg::*;

    logic              hit;
    line_meta_t        victim_meta;
    logic              meta_we;
    line_meta_t        meta_wdata;
    logic              data_we;
    logic              fill_sel;
    logic              mem_start;
    mem_req_t          ctrl_mem_req;
    logic              mem_done;
    logic [LINE_W-1:0] fill_line;
    logic [LINE_W-1:0] line_rdata;

    cache_controller ctrl_i (
        .clk          (clk),
        .proc_reset_i (proc_reset_i),
        .proc_req_i   (proc_req_i),
        .hit_i        (hit),
        .victim_meta_i(victim_meta),
        .mem_done_i   (mem_done),
        .proc_stall_o (proc_stall_o),
        .meta_we_o    (meta_we),
        .meta_wdata_o (meta_wdata),
        .data_we_o    (data_we),
        .fill_sel_o   (fill_sel),
        .mem_start_o  (mem_start),
        .mem_req_o    (ctrl_mem_req)
    );

    cache_tag_store tags_i (
        .clk          (clk),
        .proc_reset_i (proc_reset_i),
        .addr_i       (proc_req_i.addr),
        .we_i         (meta_we),
        .wdata_i      (meta_wdata),
        .hit_o        (hit),
        .victim_meta_o(victim_meta)
    );

    // store data comes straight from the processor request
    cache_data_store data_i (
        .clk         (clk),
        .addr_i      (proc_req_i.addr),
        .we_i        (data_we),
        .fill_sel_i  (fill_sel),
        .word_wdata_i(proc_req_i.wdata),
        .fill_line_i (fill_line),
        .line_rdata_o(line_rdata),
        .word_rdata_o(proc_rdata_o)
    );

    cache_mem_port port_i (
        .clk         (clk),
        .proc_reset_i(proc_reset_i),
        .start_i     (mem_start),
        .req_i       (ctrl_mem_req),
        .line_wdata_i(line_rdata),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i),
        .mem_req_o   (mem_req_o),
        .done_o      (mem_done),
        .fill_line_o (fill_line)
    );

endmodule

//--- project.f
cache_pkg.sv
cache_controller.sv
cache_tag_store.sv
cache_data_store.sv
cache_mem_port.sv
cache_top.sv
cache_assertions.sv
tb_cache_top.sv

//--- tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;
    import cache_pkg::*;

    localparam int NUM_REQS     = 400;
    // dirty miss with two slow transfers rounded up
    localparam int WORST_CYCLES = 40;
    localparam int CYCLE_LIMIT  = NUM_REQS * WORST_CYCLES + 4000;

    logic              clk = 1'b0;
    logic              proc_reset;
    proc_req_t         proc_req;
    logic [WORD_W-1:0] proc_rdata;
    logic              proc_stall;
    mem_req_t          mem_req;
    logic [LINE_W-1:0] mem_rdata;
    logic              mem_ready;

    // reference flat word view plus per-index line state
    logic [WORD_W-1:0] flat_mem [128];
    bit                m_valid [NUM_LINES];
    bit                m_dirty [NUM_LINES];
    logic [1:0]        m_tag [NUM_LINES];
    logic [LINE_W-1:0] mem_lines [32];

    // transfers seen by the memory model during one request
    bit                    log_wr [$];
    logic [MEM_ADDR_W-1:0] log_addr [$];
    logic [LINE_W-1:0]     log_data [$];

    int unsigned stim_seed = 24;
    int unsigned mem_seed  = 24;
    int          checks    = 0;
    int          errors    = 0;
    int          wb_seen   = 0;
    int          cycle_count = 0;

    cache_top dut_i (
        .clk         (clk),
        .proc_reset_i(proc_reset),
        .proc_req_i  (proc_req),
        .proc_rdata_o(proc_rdata),
        .proc_stall_o(proc_stall),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic int unsigned lcg(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [WORD_W-1:0] fill_word(input logic [6:0] a);
        return 32'hC0DE_0000 ^ (32'(a) * 32'h9E37_79B1);
    endfunction

    function automatic logic [LINE_W-1:0] model_line(input logic [4:0] l);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*WORD_W +: WORD_W] = flat_mem[{l, 2'(w)}];
        end
        return line;
    endfunction

    task automatic report_mismatch(input string name, input logic [LINE_W-1:0] exp,
                                   input logic [LINE_W-1:0] got);
        errors++;
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic check_xfer(input int i, input bit exp_wr, input logic [MEM_ADDR_W-1:0] exp_addr);
        checks++;
        if (log_wr[i] != exp_wr) begin
            report_mismatch("mem_req_o.write", 128'(exp_wr), 128'(log_wr[i]));
        end
        checks++;
        if (log_addr[i] !== exp_addr) begin
            report_mismatch("mem_req_o.addr", 128'(exp_addr), 128'(log_addr[i]));
        end
    endtask

    // one processor request driven at posedge + 1 ns until it completes
    task automatic do_access(input bit wr, input logic [1:0] tag, input logic [2:0] idx,
                             input logic [1:0] off, input logic [WORD_W-1:0] wdata);
        logic [6:0]        waddr;
        logic [4:0]        vline;
        logic [LINE_W-1:0] vdata;
        bit                exp_hit;
        bit                exp_wb;
        int                n_exp;
        waddr   = {tag, idx, off};
        exp_hit = m_valid[idx] && (m_tag[idx] == tag);
        exp_wb  = !exp_hit && m_valid[idx] && m_dirty[idx];
        vline   = {m_tag[idx], idx};
        vdata   = model_line(vline);
        log_wr.delete();
        log_addr.delete();
        log_data.delete();
        proc_req.read  = !wr;
        proc_req.write = wr;
        proc_req.addr  = {23'd0, tag, idx, off};
        proc_req.wdata = wdata;
        @(negedge clk);
        checks++;
        if (proc_stall !== !exp_hit) begin
            report_mismatch("proc_stall_o", 128'(!exp_hit), 128'(proc_stall));
        end
        while (proc_stall !== 1'b0) begin
            @(negedge clk);
        end
        if (!wr) begin
            checks++;
            if (proc_rdata !== flat_mem[waddr]) begin
                report_mismatch("proc_rdata_o", 128'(flat_mem[waddr]), 128'(proc_rdata));
            end
        end
        n_exp = (exp_hit ? 0 : 1) + (exp_wb ? 1 : 0);
        checks++;
        if (log_addr.size() != n_exp) begin
            note_error($sformatf("saw %0d memory transfers, expected %0d", log_addr.size(), n_exp));
        end else if (exp_wb) begin
            wb_seen++;
            check_xfer(0, 1'b1, {23'd0, vline});
            checks++;
            if (log_data[0] !== vdata) begin
                report_mismatch("mem_req_o.wdata", vdata, log_data[0]);
            end
            check_xfer(1, 1'b0, {23'd0, tag, idx});
        end else if (!exp_hit) begin
            check_xfer(0, 1'b0, {23'd0, tag, idx});
        end
        if (wr) begin
            flat_mem[waddr] = wdata;
        end
        m_dirty[idx] = exp_hit ? (m_dirty[idx] | wr) : wr;
        m_valid[idx] = 1'b1;
        m_tag[idx]   = tag;
        @(posedge clk);
        #1;
    endtask

    task automatic random_access(input int write_pct, input bit narrow);
        logic [31:0] r;
        logic [31:0] d;
        logic [2:0]  idx;
        stim_seed = lcg(stim_seed);
        r         = stim_seed;
        stim_seed = lcg(stim_seed);
        d         = stim_seed;
        // narrow runs stay on two indices so evictions pile up
        idx = narrow ? {2'b00, r[18]} : r[20:18];
        do_access(int'(r[31:24]) % 100 < write_pct, r[17:16], idx, r[22:21], d);
    endtask

    task automatic end_test(input string name, input int err_mark);
        $display("test %s finished, %0d errors", name, errors - err_mark);
    endtask

    // line memory answering after 0 to 5 extra cycles with ready low
    initial begin
        int       delay;
        mem_req_t held;
        delay     = -1;
        held      = '0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        for (int a = 0; a < 128; a++) begin
            mem_lines[a/4][(a%4)*WORD_W +: WORD_W] = fill_word(7'(a));
        end
        forever begin
            @(posedge clk);
            #1;
            if (mem_ready) begin
                delay = -1;
            end
            mem_ready = 1'b0;
            if (mem_req.read || mem_req.write) begin
                checks++;
                if (mem_req.read && mem_req.write) begin
                    note_error("memory read and write requested together");
                end
                if (delay < 0) begin
                    // new request, pick its latency
                    held     = mem_req;
                    mem_seed = lcg(mem_seed);
                    delay    = int'(mem_seed[31:16]) % 6;
                end else begin
                    checks++;
                    if (mem_req !== held) begin
                        note_error("memory request changed while ready was low");
                    end
                end
                if (delay == 0) begin
                    log_wr.push_back(mem_req.write);
                    log_addr.push_back(mem_req.addr);
                    log_data.push_back(mem_req.wdata);
                    if (mem_req.write) begin
                        mem_lines[mem_req.addr[4:0]] = mem_req.wdata;
                    end else begin
                        mem_rdata = mem_lines[mem_req.addr[4:0]];
                    end
                    mem_ready = 1'b1;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        int err_mark;
        int assert_fails;
        proc_reset = 1'b1;
        proc_req   = '0;
        for (int a = 0; a < 128; a++) begin
            flat_mem[a] = fill_word(7'(a));
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
            m_tag[i]   = 2'd0;
        end
        repeat (2) @(posedge clk);
        #1;
        proc_reset = 1'b0;

        err_mark = errors;
        @(negedge clk);
        checks++;
        if (proc_stall !== 1'b0) begin
            report_mismatch("proc_stall_o", 128'(0), 128'(proc_stall));
        end
        checks++;
        if (mem_req.read !== 1'b0 || mem_req.write !== 1'b0) begin
            note_error("memory request active right after reset");
        end
        @(posedge clk);
        #1;
        end_test("reset", err_mark);

        err_mark = errors;
        repeat (100) random_access(0, 1'b0);
        end_test("random_reads", err_mark);

        err_mark = errors;
        repeat (250) random_access(50, 1'b0);
        end_test("mixed_traffic", err_mark);

        err_mark = errors;
        repeat (50) random_access(75, 1'b1);
        checks++;
        if (wb_seen == 0) begin
            note_error("no dirty eviction happened during the run");
        end
        end_test("dirty_evictions", err_mark);
        proc_req = '0;

        assert_fails = dut_i.ctrl_i.assert_i.fail_count;
        $display("summary: %0d checks, %0d errors, %0d assertion failures, %0d writebacks",
                 checks, errors, assert_fails, wb_seen);
        if (errors == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
